// ==== hw/icache_cfg_pkg.sv ====
// Instruction cache geometry
// Direct mapped, 16 lines of 16 words, 32-bit byte addresses
// Address layout is tag [31:10], line index [9:6], word index [5:2]
package icache_cfg_pkg;

	localparam int num_lines      = 16;
	localparam int words_per_line = 16;

	localparam int word_lsb = 2;  // Byte offset bits below the word index
	localparam int line_lsb = 6;
	localparam int tag_lsb  = 10;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [21:0] tag_t;
	typedef logic [3:0]  line_idx_t;
	typedef logic [3:0]  word_idx_t;

	function automatic tag_t addr_tag(addr_t a);
		return a[tag_lsb +: $bits(tag_t)];
	endfunction

	function automatic line_idx_t addr_line(addr_t a);
		return a[line_lsb +: $bits(line_idx_t)];
	endfunction

	function automatic word_idx_t addr_word(addr_t a);
		return a[word_lsb +: $bits(word_idx_t)];
	endfunction

endpackage

// ==== hw/icache_bus_pkg.sv ====
// Instruction cache bus types
// AXI4-Lite read channel payloads and the core fetch port payloads
package icache_bus_pkg;

	// Unprivileged secure instruction access
	localparam logic [2:0] arprot_insn = 3'b100;

	typedef enum logic [1:0] {
		okay   = 2'b00,
		exokay = 2'b01,
		slverr = 2'b10,
		decerr = 2'b11
	} axi_resp_e;

	typedef struct packed {
		icache_cfg_pkg::addr_t araddr;
		logic [2:0]            arprot;
	} axi_ar_t;

	typedef struct packed {
		icache_cfg_pkg::word_t rdata;
		axi_resp_e             rresp;
	} axi_r_t;

	typedef struct packed {
		icache_cfg_pkg::addr_t addr;
	} fetch_req_t;

	typedef struct packed {
		icache_cfg_pkg::word_t data;
		logic                  err;
	} fetch_rsp_t;

endpackage

// ==== hw/icache_fetch_port.sv ====
// Instruction cache fetch port
// Takes one fetch at a time, looks it up in the line store one cycle
// after acceptance, starts a line fill on a miss and answers with a
// one-cycle response pulse
`timescale 1ns/100ps

module icache_fetch_port (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       req_valid,
	output logic                       req_ready,
	input  icache_bus_pkg::fetch_req_t req,
	output logic                       rsp_valid,
	output icache_bus_pkg::fetch_rsp_t rsp,
	output icache_cfg_pkg::addr_t      lookup_addr,
	input  logic                       hit,
	input  icache_cfg_pkg::word_t      hit_data,
	output logic                       fill_start,
	output icache_cfg_pkg::addr_t      fill_addr,
	input  logic                       fill_done,
	input  logic                       fill_err
);

	typedef enum logic [1:0] {st_idle, st_lookup, st_fill_wait, st_respond} state_t;

	state_t                     state_q;
	state_t                     state_d;
	logic                       ready_q;
	icache_cfg_pkg::addr_t      addr_q;
	icache_bus_pkg::fetch_rsp_t rsp_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle:      if (req_valid && ready_q) state_d = st_lookup;
			st_lookup:    state_d = hit ? st_respond : st_fill_wait;
			st_fill_wait: if (fill_done) state_d = fill_err ? st_respond : st_lookup;  // Error skips relookup
			st_respond:   state_d = st_idle;
			default:      state_d = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= st_idle;
			ready_q <= 1'b0;  // Low through reset, up one cycle later
		end else begin
			state_q <= state_d;
			ready_q <= (state_d == st_idle);
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == st_idle && req_valid && ready_q)
			addr_q <= req.addr;
		if (state_q == st_lookup && hit)
			rsp_q <= '{data: hit_data, err: 1'b0};
		else if (state_q == st_fill_wait && fill_done && fill_err)
			rsp_q <= '{data: '0, err: 1'b1};
	end

	assign req_ready   = ready_q;
	assign lookup_addr = addr_q;
	assign fill_start  = (state_q == st_lookup) && !hit;
	assign fill_addr   = addr_q;
	assign rsp_valid   = (state_q == st_respond);
	assign rsp         = rsp_q;

endmodule

// ==== hw/icache_line_store.sv ====
// Instruction cache line store
// Valid bits, tags and data words for 16 direct-mapped lines
// Hit detection is combinational on the lookup address
// Only the fill path writes; flush and inval clear valid bits
`timescale 1ns/100ps

module icache_line_store (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      flush,
	input  icache_cfg_pkg::addr_t     lookup_addr,
	output logic                      hit,
	output icache_cfg_pkg::word_t     hit_data,
	input  logic                      inval,
	input  logic                      wr_en,
	input  icache_cfg_pkg::line_idx_t wr_line,
	input  icache_cfg_pkg::word_idx_t wr_word,
	input  icache_cfg_pkg::word_t     wr_data,
	input  logic                      tag_wr,
	input  icache_cfg_pkg::tag_t      tag_val
);

	localparam int num_words = icache_cfg_pkg::num_lines * icache_cfg_pkg::words_per_line;

	logic [icache_cfg_pkg::num_lines-1:0] valid_q;
	icache_cfg_pkg::tag_t                 tag_mem [icache_cfg_pkg::num_lines];
	icache_cfg_pkg::word_t                data_mem [num_words];

	icache_cfg_pkg::tag_t      lk_tag;
	icache_cfg_pkg::line_idx_t lk_line;
	icache_cfg_pkg::word_idx_t lk_word;

	assign lk_tag  = icache_cfg_pkg::addr_tag(lookup_addr);
	assign lk_line = icache_cfg_pkg::addr_line(lookup_addr);
	assign lk_word = icache_cfg_pkg::addr_word(lookup_addr);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else if (flush) begin
			valid_q <= '0;  // Flush wins over a fill in progress
		end else begin
			if (inval)
				valid_q[wr_line] <= 1'b0;  // Fill start
			if (tag_wr)
				valid_q[wr_line] <= 1'b1;  // Last clean beat
		end
	end

	always_ff @(posedge clk) begin
		if (tag_wr)
			tag_mem[wr_line] <= tag_val;
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			data_mem[{wr_line, wr_word}] <= wr_data;  // Line major word order
	end

	assign hit      = valid_q[lk_line] && (tag_mem[lk_line] == lk_tag);
	assign hit_data = data_mem[{lk_line, lk_word}];

endmodule

// ==== hw/icache_fill_ctrl.sv ====
// Instruction cache fill controller
// AXI4-Lite read master that fetches a whole line, word 0 first,
// with one AR in flight at a time. Each beat is written to the line
// store; the tag and valid bit are set only if no beat returned an error
`timescale 1ns/100ps

module icache_fill_ctrl (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      fill_start,
	input  icache_cfg_pkg::addr_t     fill_addr,
	output logic                      fill_done,
	output logic                      fill_err,
	output logic                      inval,
	output logic                      wr_en,
	output icache_cfg_pkg::line_idx_t wr_line,
	output icache_cfg_pkg::word_idx_t wr_word,
	output icache_cfg_pkg::word_t     wr_data,
	output logic                      tag_wr,
	output icache_cfg_pkg::tag_t      tag_val,
	output logic                      arvalid,
	input  logic                      arready,
	output icache_bus_pkg::axi_ar_t   ar,
	input  logic                      rvalid,
	output logic                      rready,
	input  icache_bus_pkg::axi_r_t    r
);

	typedef enum logic [1:0] {st_idle, st_addr, st_data, st_done} state_t;

	localparam icache_cfg_pkg::word_idx_t last_word =
		icache_cfg_pkg::word_idx_t'(icache_cfg_pkg::words_per_line - 1);

	state_t                    state_q;
	icache_cfg_pkg::word_idx_t cnt_q;
	logic                      err_q;
	logic                      inval_q;
	icache_cfg_pkg::tag_t      tag_q;
	icache_cfg_pkg::line_idx_t line_q;

	logic beat;
	logic beat_err;
	logic last_beat;

	assign beat      = (state_q == st_data) && rvalid;
	assign beat_err  = (r.rresp == icache_bus_pkg::slverr) || (r.rresp == icache_bus_pkg::decerr);
	assign last_beat = beat && (cnt_q == last_word);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= st_idle;
			cnt_q   <= '0;
			err_q   <= 1'b0;
			inval_q <= 1'b0;
		end else begin
			inval_q <= 1'b0;
			case (state_q)
				st_idle: begin
					if (fill_start) begin
						state_q <= st_addr;
						cnt_q   <= '0;
						err_q   <= 1'b0;
						inval_q <= 1'b1;  // Drop the old line before any beat lands
					end
				end
				st_addr: if (arready) state_q <= st_data;
				st_data: begin
					if (rvalid) begin
						err_q   <= err_q | beat_err;  // Keep going after an error
						cnt_q   <= cnt_q + 1'b1;
						state_q <= last_beat ? st_done : st_addr;
					end
				end
				st_done: state_q <= st_idle;
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == st_idle && fill_start) begin
			tag_q  <= icache_cfg_pkg::addr_tag(fill_addr);
			line_q <= icache_cfg_pkg::addr_line(fill_addr);
		end
	end

	assign arvalid   = (state_q == st_addr);
	assign ar.araddr = {tag_q, line_q, cnt_q, 2'b00};  // Line base plus word offset
	assign ar.arprot = icache_bus_pkg::arprot_insn;
	assign rready    = (state_q == st_data);

	assign inval   = inval_q;
	assign wr_en   = beat;
	assign wr_line = line_q;
	assign wr_word = cnt_q;
	assign wr_data = r.rdata;
	assign tag_wr  = last_beat && !(err_q | beat_err);
	assign tag_val = tag_q;

	assign fill_done = (state_q == st_done);
	assign fill_err  = err_q;

endmodule

// ==== hw/icache_top.sv ====
// Instruction cache top level
// Fetch port in front, line store in the middle, fill controller
// as the AXI4-Lite read master toward memory
`timescale 1ns/100ps

module icache_top (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       flush,
	input  logic                       req_valid,
	output logic                       req_ready,
	input  icache_bus_pkg::fetch_req_t req,
	output logic                       rsp_valid,
	output icache_bus_pkg::fetch_rsp_t rsp,
	output logic                       arvalid,
	input  logic                       arready,
	output icache_bus_pkg::axi_ar_t    ar,
	input  logic                       rvalid,
	output logic                       rready,
	input  icache_bus_pkg::axi_r_t     r
);

	icache_cfg_pkg::addr_t     lookup_addr;
	logic                      hit;
	icache_cfg_pkg::word_t     hit_data;
	logic                      fill_start;
	icache_cfg_pkg::addr_t     fill_addr;
	logic                      fill_done;
	logic                      fill_err;
	logic                      inval;
	logic                      wr_en;
	icache_cfg_pkg::line_idx_t wr_line;
	icache_cfg_pkg::word_idx_t wr_word;
	icache_cfg_pkg::word_t     wr_data;
	logic                      tag_wr;
	icache_cfg_pkg::tag_t      tag_val;

	icache_fetch_port u_fetch_port (
		.clk, .arst_n,
		.req_valid, .req_ready, .req,
		.rsp_valid, .rsp,
		.lookup_addr, .hit, .hit_data,
		.fill_start, .fill_addr, .fill_done, .fill_err
	);

	icache_line_store u_line_store (
		.clk, .arst_n, .flush,
		.lookup_addr, .hit, .hit_data,
		.inval, .wr_en, .wr_line, .wr_word, .wr_data,
		.tag_wr, .tag_val
	);

	icache_fill_ctrl u_fill_ctrl (
		.clk, .arst_n,
		.fill_start, .fill_addr, .fill_done, .fill_err,
		.inval, .wr_en, .wr_line, .wr_word, .wr_data,
		.tag_wr, .tag_val,
		.arvalid, .arready, .ar,
		.rvalid, .rready, .r
	);

endmodule

// ==== verif/tb_clock_gen.sv ====
// Testbench clock and reset
// 40 ns clock, reset held low for 16 cycles and released on a falling edge
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

// ==== verif/icache_mem_model.sv ====
// AXI4-Lite read slave for the cache testbench
// Word at address A is A ^ 32'h5a5a_0000, bit 31 set answers slverr
// Ready and valid delays of 0 to 3 cycles come from a Fibonacci LFSR
`timescale 1ns/100ps

module icache_mem_model (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    arvalid,
	output logic                    arready,
	input  icache_bus_pkg::axi_ar_t ar,
	output logic                    rvalid,
	input  logic                    rready,
	output icache_bus_pkg::axi_r_t  r
);

	typedef enum logic [1:0] {m_idle, m_accept, m_delay, m_beat} mstate_t;

	mstate_t               state;
	logic [1:0]            wait_cnt;
	logic [31:0]           lfsr;
	icache_cfg_pkg::addr_t addr_q;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Two steps, one bit taken per step
	function automatic logic [1:0] delay_bits(input logic [31:0] s);
		logic [31:0] s1;
		logic [31:0] s2;
		s1 = lfsr_step(s);
		s2 = lfsr_step(s1);
		return {s2[0], s1[0]};
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= m_idle;
			arready  <= 1'b0;
			rvalid   <= 1'b0;
			r        <= '0;
			wait_cnt <= 2'd0;
			lfsr     <= 32'h6e35_c652;
			addr_q   <= '0;
		end else begin
			case (state)
				m_idle: begin
					if (arvalid) begin
						if (wait_cnt == 2'd0) begin
							arready <= 1'b1;
							state   <= m_accept;
						end else begin
							wait_cnt <= wait_cnt - 2'd1;
						end
					end
				end
				m_accept: begin
					arready  <= 1'b0;  // AR handshake on this edge
					addr_q   <= ar.araddr;
					wait_cnt <= delay_bits(lfsr);
					lfsr     <= lfsr_step(lfsr_step(lfsr));
					state    <= m_delay;
				end
				m_delay: begin
					if (wait_cnt == 2'd0) begin
						rvalid   <= 1'b1;
						r.rdata  <= addr_q ^ 32'h5a5a_0000;
						r.rresp  <= addr_q[31] ? icache_bus_pkg::slverr : icache_bus_pkg::okay;
						state    <= m_beat;
					end else begin
						wait_cnt <= wait_cnt - 2'd1;
					end
				end
				m_beat: begin
					if (rready) begin
						rvalid   <= 1'b0;
						wait_cnt <= delay_bits(lfsr);  // Delay before next arready
						lfsr     <= lfsr_step(lfsr_step(lfsr));
						state    <= m_idle;
					end
				end
				default: state <= m_idle;
			endcase
		end
	end

endmodule

// ==== verif/icache_tb.sv ====
// Instruction cache testbench
// Replays the fetch trace against the cache with an AXI4-Lite memory
// model behind it, and checks returned words, error flags, AR counts,
// AR address order and protection within a fill and hit latency
`timescale 1ns/100ps

module icache_tb;

	localparam int ready_timeout = 64;
	localparam int rsp_timeout   = 2000;

	logic                       clk;
	logic                       arst_n;
	logic                       flush;
	logic                       req_valid;
	logic                       req_ready;
	icache_bus_pkg::fetch_req_t req;
	logic                       rsp_valid;
	icache_bus_pkg::fetch_rsp_t rsp;
	logic                       arvalid;
	logic                       arready;
	icache_bus_pkg::axi_ar_t    ar;
	logic                       rvalid;
	logic                       rready;
	icache_bus_pkg::axi_r_t     r;

	icache_cfg_pkg::addr_t cur_addr = '0;  // Fetch whose fill the AR monitor follows
	int   ar_count     = 0;
	int   rsp_errors   = 0;
	int   count_errors = 0;
	int   ar_errors    = 0;
	logic aborted      = 1'b0;

	tb_clock_gen u_clock_gen (.clk, .arst_n);

	icache_top u_dut (
		.clk, .arst_n, .flush,
		.req_valid, .req_ready, .req,
		.rsp_valid, .rsp,
		.arvalid, .arready, .ar,
		.rvalid, .rready, .r
	);

	icache_mem_model u_mem (.clk, .arst_n, .arvalid, .arready, .ar, .rvalid, .rready, .r);

	task automatic check_rsp(input icache_bus_pkg::fetch_rsp_t got,
			input icache_bus_pkg::fetch_rsp_t exp);
		if (got !== exp) begin
			rsp_errors++;
			$display("Error at %0t: fetch %h returned data %h err %0b, expected %h err %0b",
				$time, cur_addr, got.data, got.err, exp.data, exp.err);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			count_errors++;
			$display("Error at %0t: fetch %h %s is %0d, expected %0d",
				$time, cur_addr, what, got, exp);
		end
	endtask

	task automatic check_ar(input icache_bus_pkg::axi_ar_t got,
			input icache_bus_pkg::axi_ar_t exp);
		if (got !== exp) begin
			ar_errors++;
			$display("Error at %0t: AR addr %h prot %b, expected addr %h prot %b",
				$time, got.araddr, got.arprot, exp.araddr, exp.arprot);
		end
	endtask

	function automatic icache_bus_pkg::axi_ar_t expected_ar(input icache_cfg_pkg::addr_t addr,
			input int beat);
		icache_bus_pkg::axi_ar_t exp;
		exp.araddr = {addr[31:6], beat[3:0], 2'b00};  // Words of the line in order
		exp.arprot = 3'b100;  // Unprivileged secure instruction access
		return exp;
	endfunction

	// AR handshake is visible half a cycle before the edge that takes it
	always @(negedge clk) begin
		if (arst_n && arvalid && arready) begin
			check_ar(ar, expected_ar(cur_addr, ar_count));
			ar_count <= ar_count + 1;
		end
	end

	task automatic fetch_and_check(input icache_cfg_pkg::addr_t addr,
			input icache_bus_pkg::fetch_rsp_t exp, input int exp_count, input logic is_hit);
		int   waited;
		int   edges;
		logic seen;
		icache_bus_pkg::fetch_rsp_t got;
		cur_addr = addr;
		@(posedge clk);
		req_valid  <= 1'b1;
		req.addr   <= addr;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < ready_timeout) begin
			@(negedge clk);
			if (req_ready)
				seen = 1'b1;
			else
				waited++;
		end
		if (!seen) begin
			$display("Timeout: fetch %h was not accepted within %0d cycles", addr, ready_timeout);
			aborted = 1'b1;
		end else begin
			@(posedge clk);  // Acceptance edge
			req_valid <= 1'b0;
			edges = 0;
			seen  = 1'b0;
			got   = '0;
			while (!seen && edges < rsp_timeout) begin
				@(negedge clk);
				if (rsp_valid) begin
					seen = 1'b1;
					got  = rsp;
				end else begin
					@(posedge clk);
					edges++;
				end
			end
			if (!seen) begin
				$display("Timeout: no response to fetch %h within %0d cycles", addr, rsp_timeout);
				aborted = 1'b1;
			end else begin
				check_rsp(got, exp);
				check_count("AR transfer count", ar_count, exp_count);
				if (is_hit)
					check_count("hit latency in edges", edges + 1, 2);
			end
		end
	endtask

	task automatic apply_flush(input int exp_count);
		@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		check_count("AR transfer count after flush", ar_count, exp_count);
	endtask

	initial begin
		int    fd;
		int    code;
		int    waited;
		int    prev_count;
		int    tr_err;
		int    tr_count;
		byte   op;
		string line;
		icache_cfg_pkg::addr_t      tr_addr;
		icache_cfg_pkg::word_t      tr_data;
		icache_bus_pkg::fetch_rsp_t exp_rsp;

		flush     <= 1'b0;
		req_valid <= 1'b0;
		req       <= '0;
		prev_count = 0;
		waited     = 0;
		while (arst_n !== 1'b1 && waited < 64) begin
			@(posedge clk);
			waited++;
		end
		fd = $fopen("verif/icache_fetch_trace.txt", "r");
		if (arst_n !== 1'b1) begin
			$display("Timeout: reset was never released");
			aborted = 1'b1;
		end else if (fd == 0) begin
			$display("Cannot open trace file verif/icache_fetch_trace.txt");
			aborted = 1'b1;
		end
		while (fd != 0 && !aborted && !$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (line.len() > 1 && line.getc(0) != "#") begin
				op   = line.getc(0);
				code = $sscanf(line.substr(1, line.len() - 1), "%h %h %d %d",
					tr_addr, tr_data, tr_err, tr_count);
				exp_rsp.data = tr_data;
				exp_rsp.err  = tr_err[0];
				if (code != 4 || (op != "F" && op != "X")) begin
					$display("Malformed trace line: %s", line);
					aborted = 1'b1;
				end else if (op == "F") begin
					// No new AR transfers and no error means the fetch must hit
					fetch_and_check(tr_addr, exp_rsp, tr_count,
						(tr_count == prev_count) && (tr_err == 0));
				end else begin
					apply_flush(tr_count);
				end
				prev_count = tr_count;
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("Errors: response %0d, count and latency %0d, AR request %0d",
			rsp_errors, count_errors, ar_errors);
		if (!aborted && (rsp_errors + count_errors + ar_errors) == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
hw/icache_cfg_pkg.sv
hw/icache_bus_pkg.sv
hw/icache_fetch_port.sv
hw/icache_line_store.sv
hw/icache_fill_ctrl.sv
hw/icache_top.sv
verif/tb_clock_gen.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

// ==== Makefile ====
RTL = hw/icache_cfg_pkg.sv hw/icache_bus_pkg.sv hw/icache_fetch_port.sv \
      hw/icache_line_store.sv hw/icache_fill_ctrl.sv hw/icache_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module icache_top $(RTL)

sim:
	verilator --binary --timing --top-module icache_tb -f src.f --Mdir obj_dir
	./obj_dir/Vicache_tb | tee sim.log
	grep -qx "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/icache_fetch_trace.txt ====
# op addr data err ar_count, with F a fetch and X a flush (addr and data ignored)
# addr and data in hex, err and ar_count in decimal, ar_count is the running AR total
# cold miss on line 1, then hits in the same line
F 00001048 5a5a1048 0 16
F 00001040 5a5a1040 0 16
F 0000107c 5a5a107c 0 16
F 00001060 5a5a1060 0 16
# line 1 with two tags, each evicting the other
F 00002048 5a5a2048 0 32
F 00001044 5a5a1044 0 48
F 00002050 5a5a2050 0 64
F 00002054 5a5a2054 0 64
F 00003000 5a5a3000 0 80
F 00003004 5a5a3004 0 80
# flush, then both cached lines miss again
X 00000000 00000000 0 80
F 00002054 5a5a2054 0 96
F 00003008 5a5a3008 0 112
F 00003008 5a5a3008 0 112
# slverr fills leave the line invalid
F 80000100 00000000 1 128
F 80000100 00000000 1 144
F 00000104 5a5a0104 0 160
F 00000108 5a5a0108 0 160
F 80003000 00000000 1 176
F 0000300c 5a5a300c 0 192
